// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen (
	output logic o_sys_clk,
	output logic o_reset_n
);

	// 8 ns period
	initial begin
		o_sys_clk = 1'b0;
		forever #4 o_sys_clk = ~o_sys_clk;
	end

	// Reset held low for eight clocks
	initial begin
		o_reset_n = 1'b0;
		repeat (8) @(posedge o_sys_clk);
		o_reset_n <= 1'b1;
	end

endmodule

// ==== bench/uart_rx_tb.sv ====
`timescale 1ns/100ps

`include "uart_rx_params.svh"

module uart_rx_tb;

	import uart_rx_pkg::*;

	localparam int NCH      = `UART_CHANNELS;
	localparam int TICK_DIV = `UART_TICK_DIV;
	localparam int BIT_CLKS = `UART_OVERSAMPLE * `UART_TICK_DIV;
	localparam int TIMEOUT  = 2000;
	// Glitch window inside a data bit, three ticks wide
	localparam int GL_FIRST = 6 * TICK_DIV;
	localparam int GL_LAST  = 9 * TICK_DIV;

	logic           sys_clk;
	logic           reset_n;
	logic [NCH-1:0] rx_line;
	rx_word_t       word;
	logic           word_valid;

	// Scoreboard, one queue per channel
	rx_frame_t      exp_q [NCH][$];
	rx_frame_t      exp_head [NCH];
	logic [NCH-1:0] exp_any;
	logic           frame_sent;
	string          test_name;

	// Frame image per lane, bit 0 is the start bit
	logic [10:0]    lane_bits [NCH];
	logic [NCH-1:0] lane_glitch;
	logic [7:0]     lfsr_state;

	tb_clock_gen tb_clock_gen_inst (
		.o_sys_clk (sys_clk),
		.o_reset_n (reset_n)
	);

	uart_rx_top #(
		.PARITY_MODE (PARITY_EVEN)
	) uart_rx_top_inst (
		.i_sys_clk    (sys_clk),
		.i_reset_n    (reset_n),
		.i_rx_line    (rx_line),
		.o_word       (word),
		.o_word_valid (word_valid)
	);

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("Finished with errors");
		$fatal(1, "Run stopped at the first error");
	endtask

	// Galois form, taps 8 6 5 4
	function automatic logic [7:0] lfsr_next(input logic [7:0] s);
		return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
	endfunction

	// One step per data bit
	task automatic next_byte(output logic [7:0] b);
		for (int i = 0; i < 8; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			b[i] = lfsr_state[0];
		end
	endtask

	task automatic update_heads();
		for (int ch = 0; ch < NCH; ch++) begin
			exp_any[ch] = (exp_q[ch].size() != 0);
			if (exp_any[ch]) begin
				exp_head[ch] = exp_q[ch][0];
			end else begin
				exp_head[ch] = '0;
			end
		end
	endtask

	// Even parity bit makes the count of ones even
	task automatic load_frame(input int ch, input logic [7:0] data, input logic bad_par,
			input logic bad_stop, input logic glitch);
		rx_frame_t exp;
		logic      par;
		par              = ^data ^ bad_par;
		lane_bits[ch]    = {~bad_stop, par, data, 1'b0};
		lane_glitch[ch]  = glitch;
		exp.data         = data;
		exp.parity_err   = bad_par;
		exp.frame_err    = bad_stop;
		exp_q[ch].push_back(exp);
		frame_sent       = 1'b1;
		update_heads();
	endtask

	function automatic logic lane_level(input int ch, input int b, input int k);
		logic lvl;
		// Bit 11 is the idle gap after the stop bit
		lvl = (b > 10) ? 1'b1 : lane_bits[ch][b];
		if (lane_glitch[ch] && b >= 1 && b <= 8 && k >= GL_FIRST && k < GL_LAST) begin
			lvl = ~lvl;
		end
		return lvl;
	endfunction

	// All lanes in the mask start in the same clock
	task automatic drive_lanes(input logic [NCH-1:0] mask);
		logic [NCH-1:0] next_line;
		for (int b = 0; b < 12; b++) begin
			for (int k = 0; k < BIT_CLKS; k++) begin
				@(posedge sys_clk);
				next_line = '1;
				for (int ch = 0; ch < NCH; ch++) begin
					if (mask[ch]) begin
						next_line[ch] = lane_level(ch, b, k);
					end
				end
				rx_line <= next_line;
			end
		end
	endtask

	task automatic wait_drained();
		int n;
		int pending;
		n       = 0;
		pending = 0;
		while (exp_any != '0 && n < TIMEOUT) begin
			@(posedge sys_clk);
			n++;
		end
		if (exp_any != '0) begin
			for (int ch = NCH - 1; ch >= 0; ch--) begin
				if (exp_any[ch]) begin
					pending = ch;
				end
			end
			fail_run($sformatf("Timeout in test %s, frame on channel %0d never arrived",
				test_name, pending));
		end
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		while (!reset_n && n < TIMEOUT) begin
			@(posedge sys_clk);
			n++;
		end
		if (!reset_n) begin
			fail_run("Timeout waiting for reset release");
		end
	endtask

	task automatic send_and_check(input logic [NCH-1:0] mask);
		drive_lanes(mask);
		wait_drained();
	endtask

	//////////////////////////////////////////////////
	// Checks on the output word
	//////////////////////////////////////////////////

	// Word seen at one negedge retires at the next posedge
	always @(posedge sys_clk) begin
		if (word_valid) begin
			if (exp_q[word.channel].size() != 0) begin
				void'(exp_q[word.channel].pop_front());
			end
			update_heads();
		end
	end

	a_quiet: assert property (@(negedge sys_clk) disable iff (!reset_n)
		!frame_sent |-> !word_valid)
		else fail_run("Output word seen before any frame was sent");

	// Duplicates land here too
	a_word_expected: assert property (@(negedge sys_clk) disable iff (!reset_n)
		word_valid |-> exp_any[word.channel])
		else fail_run($sformatf("Word on channel %0d with no frame pending", word.channel));

	a_word_match: assert property (@(negedge sys_clk) disable iff (!reset_n)
		(word_valid && exp_any[word.channel]) |-> (word.frame == exp_head[word.channel]))
		else fail_run($sformatf("MISMATCH test %s channel %0d expected %h actual %h",
			test_name, word.channel, exp_head[word.channel], word.frame));

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		logic [7:0] d;
		rx_line     = '1;
		lane_glitch = '0;
		frame_sent  = 1'b0;
		lfsr_state  = 8'd53;
		test_name   = "reset";
		update_heads();
		wait_reset_release();
		// Idle line, nothing may come out
		repeat (200) @(posedge sys_clk);

		test_name = "single_frame";
		for (int ch = 0; ch < NCH; ch++) begin
			next_byte(d);
			load_frame(ch, d, 1'b0, 1'b0, 1'b0);
			send_and_check(NCH'(1) << ch);
		end

		test_name = "bad_parity";
		for (int ch = 0; ch < NCH; ch++) begin
			next_byte(d);
			load_frame(ch, d, 1'b1, 1'b0, 1'b0);
			send_and_check(NCH'(1) << ch);
		end

		test_name = "bad_stop";
		for (int ch = 0; ch < NCH; ch++) begin
			next_byte(d);
			load_frame(ch, d, 1'b0, 1'b1, 1'b0);
			send_and_check(NCH'(1) << ch);
		end

		// Four dones in one clock, collector contention
		test_name = "all_channels";
		for (int r = 0; r < 3; r++) begin
			for (int ch = 0; ch < NCH; ch++) begin
				next_byte(d);
				load_frame(ch, d, 1'b0, 1'b0, 1'b0);
			end
			send_and_check('1);
		end

		test_name = "glitch";
		for (int ch = 0; ch < NCH; ch++) begin
			load_frame(ch, ch[0] ? 8'h5A : 8'hA5, 1'b0, 1'b0, 1'b1);
		end
		send_and_check('1);
		for (int ch = 0; ch < NCH; ch++) begin
			next_byte(d);
			load_frame(ch, d, 1'b0, 1'b0, 1'b1);
		end
		send_and_check('1);

		if (exp_any == '0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			fail_run("Frames left without an output word at the end of the run");
		end
	end

endmodule

// ==== filelist.f ====
+incdir+include
verilog/uart_rx_pkg.sv
verilog/uart_baud_tick.sv
verilog/uart_rx_channel.sv
verilog/uart_rx_collector.sv
verilog/uart_rx_top.sv
bench/tb_clock_gen.sv
bench/uart_rx_tb.sv

// ==== include/uart_rx_params.svh ====
`ifndef UART_RX_PARAMS_SVH
`define UART_RX_PARAMS_SVH

// Number of receive channels
`define UART_CHANNELS 4

// Ticks per serial bit
// Fixed ratio, the channel counters rely on it
`define UART_OVERSAMPLE 16

// System clocks per oversample tick
// 4 gives 64 clocks per bit
`define UART_TICK_DIV 4

`endif

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the UART receive testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
	--top-module uart_rx_tb -f filelist.f -o uart_rx_sim; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/uart_rx_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "Finished with no errors" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

// ==== verilog/uart_baud_tick.sv ====
`timescale 1ns/100ps

`include "uart_rx_params.svh"

module uart_baud_tick (
	input  logic i_sys_clk,
	input  logic i_reset_n,
	output logic o_tick
);

	localparam int TICK_DIV = `UART_TICK_DIV;
	localparam int CNT_W    = $clog2(TICK_DIV + 1);

	// Clocks left until the next strobe
	logic [CNT_W-1:0] div_cnt;

	//////////////////////////////////////////////////
	// Divider
	//////////////////////////////////////////////////

	always_ff @(posedge i_sys_clk or negedge i_reset_n) begin
		if (!i_reset_n) begin
			div_cnt <= CNT_W'(TICK_DIV - 1);
			o_tick  <= 1'b0;
		end else if (div_cnt == '0) begin
			// Reload and fire one strobe
			div_cnt <= CNT_W'(TICK_DIV - 1);
			o_tick  <= 1'b1;
		end else begin
			div_cnt <= div_cnt - 1'b1;
			o_tick  <= 1'b0;
		end
	end

	// Tick must stay a single-clock strobe
	// Needs a divide ratio of at least 2
	a_tick_single: assert property (@(posedge i_sys_clk) disable iff (!i_reset_n)
		o_tick |=> !o_tick);

endmodule

// ==== verilog/uart_rx_channel.sv ====
`timescale 1ns/100ps

`include "uart_rx_params.svh"

module uart_rx_channel #(
	parameter uart_rx_pkg::parity_mode_e PARITY_MODE = uart_rx_pkg::PARITY_NONE
) (
	input  logic                   i_sys_clk,
	input  logic                   i_reset_n,
	input  logic                   i_tick,
	input  logic                   i_rx_line,
	output uart_rx_pkg::rx_frame_t o_frame,
	output logic                   o_busy,
	output logic                   o_done
);

	import uart_rx_pkg::*;

	localparam int OVERSAMPLE = `UART_OVERSAMPLE;
	localparam int CNT_W      = $clog2(OVERSAMPLE);
	// Data bits plus the optional parity bit
	localparam int RX_BITS    = (PARITY_MODE == PARITY_NONE) ? 8 : 9;

	logic [1:0]         sync_ff;
	logic [1:0]         line_hist;
	rx_state_e          state;
	rx_state_e          state_nxt;
	logic [CNT_W-1:0]   tick_cnt;
	logic [CNT_W-1:0]   high_cnt;
	logic [CNT_W:0]     high_sum;
	logic [3:0]         bit_cnt;
	logic [RX_BITS-1:0] shreg;
	logic               start_edge;
	logic               start_end;
	logic               bit_end;
	logic               last_bit;
	logic               bit_val;
	logic [7:0]         rx_data;
	logic               rx_par;
	logic               parity_err;
	logic               busy_q;

	//////////////////////////////////////////////////
	// Line input
	//////////////////////////////////////////////////

	// Two-flop synchronizer
	// Idle line is high
	always_ff @(posedge i_sys_clk or negedge i_reset_n) begin
		if (!i_reset_n) begin
			sync_ff <= 2'b11;
		end else begin
			sync_ff <= {sync_ff[0], i_rx_line};
		end
	end

	// Line history taken once per tick
	// Bit 0 is the newest sample
	always_ff @(posedge i_sys_clk or negedge i_reset_n) begin
		if (!i_reset_n) begin
			line_hist <= 2'b11;
		end else if (i_tick) begin
			line_hist <= {line_hist[0], sync_ff[1]};
		end
	end

	assign start_edge = (line_hist == 2'b10);
	// Start state covers one tick less than a bit
	assign start_end  = (tick_cnt == CNT_W'(OVERSAMPLE - 2));
	assign bit_end    = (tick_cnt == CNT_W'(OVERSAMPLE - 1));
	assign last_bit   = (bit_cnt == 4'(RX_BITS - 1));

	// Majority over all samples of the bit
	// Current sample included
	assign high_sum = {1'b0, high_cnt} + (CNT_W + 1)'(line_hist[0]);
	assign bit_val  = (high_sum > (CNT_W + 1)'(OVERSAMPLE / 2));

	//////////////////////////////////////////////////
	// Receiver FSM
	//////////////////////////////////////////////////

	always_comb begin
		state_nxt = state;
		case (state)
			RX_IDLE: begin
				if (start_edge) begin
					state_nxt = RX_START;
				end
			end
			RX_START: begin
				if (start_end) begin
					state_nxt = RX_DATA;
				end
			end
			RX_DATA: begin
				if (bit_end && last_bit) begin
					state_nxt = RX_STOP;
				end
			end
			default: begin
				// Stop lasts a single tick
				state_nxt = RX_IDLE;
			end
		endcase
	end

	always_ff @(posedge i_sys_clk or negedge i_reset_n) begin
		if (!i_reset_n) begin
			state <= RX_IDLE;
		end else if (i_tick) begin
			state <= state_nxt;
		end
	end

	// Tick, sample and bit counters
	always_ff @(posedge i_sys_clk or negedge i_reset_n) begin
		if (!i_reset_n) begin
			tick_cnt <= '0;
			high_cnt <= '0;
			bit_cnt  <= '0;
		end else if (i_tick) begin
			case (state)
				RX_START: begin
					tick_cnt <= start_end ? '0 : tick_cnt + 1'b1;
				end
				RX_DATA: begin
					if (bit_end) begin
						tick_cnt <= '0;
						high_cnt <= '0;
						bit_cnt  <= bit_cnt + 1'b1;
					end else begin
						tick_cnt <= tick_cnt + 1'b1;
						high_cnt <= high_cnt + CNT_W'(line_hist[0]);
					end
				end
				default: begin
					tick_cnt <= '0;
					high_cnt <= '0;
					bit_cnt  <= '0;
				end
			endcase
		end
	end

	// LSB first
	// Each voted bit enters at the top
	always_ff @(posedge i_sys_clk) begin
		if (i_tick && state == RX_DATA && bit_end) begin
			shreg <= {bit_val, shreg[RX_BITS-1:1]};
		end
	end

	//////////////////////////////////////////////////
	// Frame checks and outputs
	//////////////////////////////////////////////////

	assign rx_data = shreg[7:0];
	// Parity bit lands last
	// Unused without parity
	assign rx_par  = shreg[RX_BITS-1];

	always_comb begin
		case (PARITY_MODE)
			PARITY_ODD:  parity_err = ~(^rx_data ^ rx_par);
			PARITY_EVEN: parity_err = ^rx_data ^ rx_par;
			default:     parity_err = 1'b0;
		endcase
	end

	always_ff @(posedge i_sys_clk or negedge i_reset_n) begin
		if (!i_reset_n) begin
			o_frame <= '0;
			o_busy  <= 1'b0;
		end else if (i_tick) begin
			if (state == RX_IDLE && start_edge) begin
				o_busy <= 1'b1;
			end else if (state == RX_STOP) begin
				// Stop level low means a framing error
				o_frame.data       <= rx_data;
				o_frame.parity_err <= parity_err;
				o_frame.frame_err  <= ~line_hist[0];
				o_busy             <= 1'b0;
			end
		end
	end

	// Falling edge of busy marks the end of a frame
	always_ff @(posedge i_sys_clk or negedge i_reset_n) begin
		if (!i_reset_n) begin
			busy_q <= 1'b0;
		end else begin
			busy_q <= o_busy;
		end
	end

	assign o_done = busy_q & ~o_busy;

	// Done only on the clock after the single stop tick
	// Stop is one tick long so done is a one-clock pulse
	a_done_pulse: assert property (@(posedge i_sys_clk) disable iff (!i_reset_n)
		o_done == $past(state == RX_STOP && i_tick));

	// FSM only moves on a tick clock
	a_state_on_tick: assert property (@(posedge i_sys_clk) disable iff (!i_reset_n)
		!i_tick |=> $stable(state));

endmodule

// ==== verilog/uart_rx_collector.sv ====
`timescale 1ns/100ps

`include "uart_rx_params.svh"

module uart_rx_collector (
	input  logic                      i_sys_clk,
	input  logic                      i_reset_n,
	input  logic [`UART_CHANNELS-1:0] i_done,
	input  uart_rx_pkg::rx_frame_t    i_frame [`UART_CHANNELS],
	output uart_rx_pkg::rx_word_t     o_word,
	output logic                      o_word_valid
);

	import uart_rx_pkg::*;

	localparam int NCH   = `UART_CHANNELS;
	localparam int IDX_W = (NCH > 1) ? $clog2(NCH) : 1;

	logic [NCH-1:0]   slot_full;
	rx_frame_t        slot_frame [NCH];
	logic [IDX_W-1:0] rr_ptr;
	logic [IDX_W-1:0] pick_idx;
	logic             pick_valid;

	//////////////////////////////////////////////////
	// Round-robin pick
	//////////////////////////////////////////////////

	// First full slot at or after the pointer
	always_comb begin
		int idx;
		pick_valid = 1'b0;
		pick_idx   = rr_ptr;
		for (int off = 0; off < NCH; off++) begin
			idx = (int'(rr_ptr) + off) % NCH;
			if (!pick_valid && slot_full[idx]) begin
				pick_valid = 1'b1;
				pick_idx   = IDX_W'(idx);
			end
		end
	end

	//////////////////////////////////////////////////
	// Slots
	//////////////////////////////////////////////////

	always_ff @(posedge i_sys_clk or negedge i_reset_n) begin
		if (!i_reset_n) begin
			slot_full <= '0;
		end else begin
			for (int i = 0; i < NCH; i++) begin
				if (i_done[i]) begin
					slot_full[i] <= 1'b1;
				end else if (pick_valid && pick_idx == IDX_W'(i)) begin
					slot_full[i] <= 1'b0;
				end
			end
		end
	end

	// Frame held until its slot is drained
	always_ff @(posedge i_sys_clk) begin
		for (int i = 0; i < NCH; i++) begin
			if (i_done[i]) begin
				slot_frame[i] <= i_frame[i];
			end
		end
	end

	//////////////////////////////////////////////////
	// Output word
	//////////////////////////////////////////////////

	always_ff @(posedge i_sys_clk or negedge i_reset_n) begin
		if (!i_reset_n) begin
			rr_ptr       <= '0;
			o_word_valid <= 1'b0;
		end else begin
			o_word_valid <= pick_valid;
			// Next search starts past the served channel
			if (pick_valid) begin
				rr_ptr <= (pick_idx == IDX_W'(NCH - 1)) ? '0 : pick_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge i_sys_clk) begin
		o_word.channel <= 2'(pick_idx);
		o_word.frame   <= slot_frame[pick_idx];
	end

	// A channel must not finish again while its word still waits
	for (genvar g = 0; g < NCH; g++) begin : g_slot_chk
		a_no_overrun: assert property (@(posedge i_sys_clk) disable iff (!i_reset_n)
			i_done[g] |-> !slot_full[g]);
	end

endmodule

// ==== verilog/uart_rx_pkg.sv ====
package uart_rx_pkg;

	//////////////////////////////////////////////////
	// Build-time options
	//////////////////////////////////////////////////

	// Rule for the bit that follows the eight data bits
	typedef enum logic [1:0] {
		PARITY_NONE = 2'd0,
		PARITY_ODD  = 2'd1,
		PARITY_EVEN = 2'd2
	} parity_mode_e;

	// Receiver FSM states
	typedef enum logic [1:0] {
		RX_IDLE  = 2'd0,
		RX_START = 2'd1,
		RX_DATA  = 2'd2,
		RX_STOP  = 2'd3
	} rx_state_e;

	//////////////////////////////////////////////////
	// Data carried between blocks
	//////////////////////////////////////////////////

	// One received character and its status flags
	typedef struct packed {
		logic [7:0] data;
		logic       parity_err;
		logic       frame_err;
	} rx_frame_t;

	// Collector output word, tagged with its source channel
	typedef struct packed {
		logic [1:0] channel;
		rx_frame_t  frame;
	} rx_word_t;

endpackage

// ==== verilog/uart_rx_top.sv ====
`timescale 1ns/100ps

`include "uart_rx_params.svh"

module uart_rx_top #(
	parameter uart_rx_pkg::parity_mode_e PARITY_MODE = uart_rx_pkg::PARITY_EVEN
) (
	input  logic                      i_sys_clk,
	input  logic                      i_reset_n,
	input  logic [`UART_CHANNELS-1:0] i_rx_line,
	output uart_rx_pkg::rx_word_t     o_word,
	output logic                      o_word_valid
);

	import uart_rx_pkg::*;

	logic                      tick;
	logic [`UART_CHANNELS-1:0] ch_done;
	rx_frame_t                 ch_frame [`UART_CHANNELS];

	// Shared oversample strobe
	uart_baud_tick uart_baud_tick_inst (
		.i_sys_clk (i_sys_clk),
		.i_reset_n (i_reset_n),
		.o_tick    (tick)
	);

	//////////////////////////////////////////////////
	// Receive channels
	//////////////////////////////////////////////////

	for (genvar g = 0; g < `UART_CHANNELS; g++) begin : g_channel
		uart_rx_channel #(
			.PARITY_MODE (PARITY_MODE)
		) uart_rx_channel_inst (
			.i_sys_clk (i_sys_clk),
			.i_reset_n (i_reset_n),
			.i_tick    (tick),
			.i_rx_line (i_rx_line[g]),
			.o_frame   (ch_frame[g]),
			.o_busy    (),
			.o_done    (ch_done[g])
		);

		// Every finished frame leaves as a word of that channel
		a_done_to_word: assert property (@(posedge i_sys_clk) disable iff (!i_reset_n)
			ch_done[g] |-> ##[2:`UART_CHANNELS + 1]
				(o_word_valid && o_word.channel == 2'(g)));
	end

	// Drains the finished frames onto one output
	uart_rx_collector uart_rx_collector_inst (
		.i_sys_clk    (i_sys_clk),
		.i_reset_n    (i_reset_n),
		.i_done       (ch_done),
		.i_frame      (ch_frame),
		.o_word       (o_word),
		.o_word_valid (o_word_valid)
	);

endmodule
